// ==== hdl/tcp_tx_cfg.svh ====
`ifndef TCP_TX_CFG_SVH
`define TCP_TX_CFG_SVH

// option area limits
// no SACK blocks, so MSS + WS + SACK-permitted + timestamp fill at most 6 words
`define TCP_TX_MAX_OPT_WORDS 6

// header length in bytes
`define TCP_TX_MIN_HDR_BYTES 20
`define TCP_TX_MAX_HDR_BYTES 44

`endif

// ==== hdl/tcp_tx_pkg.sv ====
`default_nettype none

package tcp_tx_pkg;

  localparam logic [7:0] TCP_PROTO = 8'd6;  // ip protocol field for tcp

  // option kind bytes as they appear on the wire
  typedef enum logic [7:0] {
    opt_end       = 8'd0,
    opt_nop       = 8'd1,
    opt_mss       = 8'd2,
    opt_ws        = 8'd3,
    opt_sack_perm = 8'd4,
    opt_ts        = 8'd8
  } tcp_opt_kind_t;

  // checksum engine phases
  typedef enum logic [2:0] {
    cks_idle,
    cks_pseudo,   // 12 byte pseudo header
    cks_header,   // fixed header then options
    cks_fold,     // payload sum, carry folds, complement
    cks_done
  } cks_state_t;

  // transmit control states
  typedef enum logic [2:0] {
    tx_idle,
    tx_assemble,  // option packing in progress
    tx_checksum,  // waiting on checksum result
    tx_ready,     // out_rdy raised, waiting for out_acc
    tx_header,
    tx_payload
  } tx_state_t;

endpackage : tcp_tx_pkg

`default_nettype wire

// ==== hdl/tcp_opt_assemble.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tcp_tx_cfg.svh"

module tcp_opt_assemble
  import tcp_tx_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  opt_start,
  input  logic                                  mss_pres,
  input  logic                                  wnd_pres,
  input  logic                                  sack_perm_pres,
  input  logic                                  ts_pres,
  input  logic [15:0]                           mss,
  input  logic [7:0]                            wnd_scale,
  input  logic [31:0]                           ts_val,
  input  logic [31:0]                           ts_ecr,
  output logic                                  opt_done,
  output logic [`TCP_TX_MAX_OPT_WORDS-1:0][31:0] opt_words,
  output logic [2:0]                            opt_count,
  output logic [3:0]                            data_offset
);

  localparam int LAST_SLOT = `TCP_TX_MAX_OPT_WORDS - 1;

  logic [`TCP_TX_MAX_OPT_WORDS-1:0][31:0] proto;  // all options, top slot examined first
  logic [`TCP_TX_MAX_OPT_WORDS-1:0]       pres;
  logic [2:0]                            slot;
  logic                                  busy;

  assign data_offset = 4'd5 + {1'b0, opt_count};  // 32-bit words incl. fixed header

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      opt_done  <= 1'b0;
      slot      <= '0;
      opt_count <= '0;
    end else begin
      opt_done <= 1'b0;
      if (opt_start) begin
        busy      <= 1'b1;
        slot      <= '0;
        opt_count <= '0;
      end else if (busy) begin
        slot <= slot + 3'd1;
        if (pres[LAST_SLOT])
          opt_count <= opt_count + 3'd1;
        if (slot == 3'(LAST_SLOT)) begin  // every slot visited
          busy     <= 1'b0;
          opt_done <= 1'b1;
        end
      end
    end
  end

  // Words leave the prototype from the timestamp end and are pushed in at the
  // top of opt_words, so MSS ends up most significant and absent slots leave
  // zeros at the bottom.
  always_ff @(posedge clk) begin
    if (opt_start) begin
      proto <= {ts_ecr,
                ts_val,
                {opt_nop, opt_nop, opt_ts, 8'd10},
                {opt_nop, opt_nop, opt_sack_perm, 8'd2},
                {opt_nop, opt_ws, 8'd3, wnd_scale},
                {opt_mss, 8'd4, mss}};
      pres      <= {{3{ts_pres}}, sack_perm_pres, wnd_pres, mss_pres};
      opt_words <= '0;
    end else if (busy) begin
      proto <= {proto[LAST_SLOT-1:0], 32'h0};
      pres  <= {pres[LAST_SLOT-1:0], 1'b0};
      if (pres[LAST_SLOT])
        opt_words <= {proto[LAST_SLOT], opt_words[LAST_SLOT:1]};
    end
  end

  // stream and checksum sequencing rely on this fixed latency
  a_opt_latency: assert property (@(posedge clk) disable iff (rst)
    opt_start |-> ##(LAST_SLOT + 2) opt_done);

  a_opt_count: assert property (@(posedge clk) disable iff (rst)
    opt_done |-> opt_count <= 3'(`TCP_TX_MAX_OPT_WORDS));

endmodule : tcp_opt_assemble

`default_nettype wire

// ==== hdl/tcp_cks_calc.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tcp_tx_cfg.svh"

module tcp_cks_calc
  import tcp_tx_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  cks_start,
  input  logic [31:0]                           src_ip,
  input  logic [31:0]                           dst_ip,
  input  logic [9:0][15:0]                      hdr_words,
  input  logic [`TCP_TX_MAX_OPT_WORDS-1:0][31:0] opt_words,
  input  logic [3:0]                            data_offset,
  input  logic [15:0]                           pld_len,
  input  logic [31:0]                           pld_cks,
  output logic                                  cks_done,
  output logic [15:0]                           cks
);

  localparam int HDR_HALVES = `TCP_TX_MIN_HDR_BYTES / 2;
  localparam int LAST_HALF  = HDR_HALVES + 2 * `TCP_TX_MAX_OPT_WORDS - 1;

  cks_state_t                                state;
  logic [4:0]                                cnt;
  logic [4:0]                                last_cnt;
  logic [4:0]                                half_idx;
  logic [31:0]                               acc;
  logic [4:0][15:0]                          pseudo;  // remaining pseudo header words
  logic [31:0]                               pld_cks_r;
  logic [2*`TCP_TX_MAX_OPT_WORDS-1:0][15:0]  opt_halves;
  logic [15:0]                               cur_word;
  logic [16:0]                               fold_a;
  logic [15:0]                               fold_b;

  assign opt_halves = opt_words;
  assign last_cnt   = {data_offset, 1'b0} - 5'd1;  // header and options in 16-bit words
  assign half_idx   = (cnt < 5'(HDR_HALVES)) ? 5'(HDR_HALVES - 1) - cnt : 5'(LAST_HALF) - cnt;
  assign cur_word   = (cnt < 5'(HDR_HALVES)) ? hdr_words[half_idx[3:0]]
                                              : opt_halves[half_idx[3:0]];
  assign fold_a     = {1'b0, acc[31:16]} + {1'b0, acc[15:0]};
  assign fold_b     = fold_a[15:0] + {15'b0, fold_a[16]};

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= cks_idle;
      cnt      <= '0;
      cks_done <= 1'b0;
    end else begin
      case (state)
        cks_idle: if (cks_start) begin
          cnt   <= '0;
          state <= cks_pseudo;
        end
        cks_pseudo: begin
          cnt <= cnt + 5'd1;
          if (cnt == 5'd4) begin  // first word went in on the start edge
            cnt   <= '0;
            state <= cks_header;
          end
        end
        cks_header: begin
          cnt <= cnt + 5'd1;
          if (cnt == last_cnt) begin
            cnt   <= '0;
            state <= cks_fold;
          end
        end
        cks_fold: begin
          cnt <= 5'd1;
          if (cnt[0]) begin
            cks_done <= 1'b1;
            state    <= tcp_tx_pkg::cks_done;
          end
        end
        tcp_tx_pkg::cks_done: begin
          cks_done <= 1'b0;
          state    <= cks_idle;
        end
        default: state <= cks_idle;
      endcase
    end
  end

  // Pseudo header length is summed as pld_len here and data_offset*4 in the
  // first fold cycle, since data_offset settles only after option assembly.
  always_ff @(posedge clk) begin
    case (state)
      cks_idle: if (cks_start) begin
        acc       <= {16'h0, src_ip[31:16]};
        pseudo    <= {src_ip[15:0], dst_ip[31:16], dst_ip[15:0], {8'h00, TCP_PROTO}, pld_len};
        pld_cks_r <= pld_cks;
      end
      cks_pseudo: begin
        acc    <= acc + {16'h0, pseudo[4]};
        pseudo <= {pseudo[3:0], 16'h0};
      end
      cks_header: acc <= acc + {16'h0, cur_word};
      cks_fold: begin
        if (!cnt[0])
          acc <= {15'h0, fold_a} + {16'h0, pld_cks_r[31:16]} + {16'h0, pld_cks_r[15:0]}
                 + {26'h0, data_offset, 2'b00};
        else
          cks <= ~fold_b;  // second and third fold, then complement
      end
      default: ;
    endcase
  end

  a_start_idle: assert property (@(posedge clk) disable iff (rst)
    cks_start |-> state == cks_idle);

endmodule : tcp_cks_calc

`default_nettype wire

// ==== hdl/tcp_tx_stream.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tcp_tx_cfg.svh"

module tcp_tx_stream
  import tcp_tx_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  tx_rdy,
  input  logic [15:0]                           src_port,
  input  logic [15:0]                           dst_port,
  input  logic [31:0]                           seq_num,
  input  logic [31:0]                           ack_num,
  input  logic [8:0]                            flags,
  input  logic [15:0]                           wnd,
  input  logic [15:0]                           urg_ptr,
  input  logic [15:0]                           pld_len,
  input  logic                                  opt_done,
  input  logic [`TCP_TX_MAX_OPT_WORDS-1:0][31:0] opt_words,
  input  logic [2:0]                            opt_count,
  input  logic [3:0]                            data_offset,
  input  logic                                  cks_done,
  input  logic [15:0]                           cks,
  input  logic                                  out_acc,
  input  logic                                  strm_req,
  input  logic [7:0]                            pld_dat,
  output logic                                  tx_acc,
  output logic                                  opt_start,
  output logic                                  cks_start,
  output logic [9:0][15:0]                      hdr_words,
  output logic                                  out_rdy,
  output logic [15:0]                           ip_len,
  output logic                                  strm_val,
  output logic                                  strm_sof,
  output logic                                  strm_eof,
  output logic [7:0]                            strm_dat,
  output logic                                  pld_req
);

  localparam int TOP_BYTE = `TCP_TX_MAX_HDR_BYTES - 1;

  tx_state_t                            state;
  logic [15:0]                          src_port_r;
  logic [15:0]                          dst_port_r;
  logic [31:0]                          seq_r;
  logic [31:0]                          ack_r;
  logic [8:0]                           flags_r;
  logic [15:0]                          wnd_r;
  logic [15:0]                          urg_r;
  logic [15:0]                          pld_len_r;
  logic [15:0]                          pld_cnt;
  logic [`TCP_TX_MAX_HDR_BYTES-1:0][7:0] hdr_reg;  // byte 0 of the segment on top
  logic [5:0]                           hdr_cnt;
  logic [5:0]                           hdr_last;
  logic                                 hdr_end;
  logic                                 pld_end;
  logic                                 hdr_take;
  logic                                 seg_open;  // between sof and eof

  // checksum field left zero for the checksum engine
  assign hdr_words = {src_port_r, dst_port_r, seq_r, ack_r,
                      data_offset, 3'b000, flags_r, wnd_r, 16'h0000, urg_r};

  assign ip_len   = {10'h0, data_offset, 2'b00} + pld_len_r;
  assign hdr_last = 6'(`TCP_TX_MIN_HDR_BYTES) + {1'b0, opt_count, 2'b00} - 6'd1;
  assign hdr_end  = hdr_cnt == hdr_last;
  assign pld_end  = pld_cnt == pld_len_r - 16'd1;
  assign hdr_take = (state == tx_header) && !strm_eof && strm_req;
  assign pld_req  = (state == tx_payload) && !strm_eof && strm_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= tx_idle;
      tx_acc    <= 1'b0;
      opt_start <= 1'b0;
      cks_start <= 1'b0;
      out_rdy   <= 1'b0;
      strm_val  <= 1'b0;
      strm_sof  <= 1'b0;
      strm_eof  <= 1'b0;
      hdr_cnt   <= '0;
      pld_cnt   <= '0;
    end else begin
      tx_acc    <= 1'b0;
      opt_start <= 1'b0;
      cks_start <= 1'b0;
      case (state)
        tx_idle: if (tx_rdy) begin
          tx_acc    <= 1'b1;
          opt_start <= 1'b1;
          cks_start <= 1'b1;  // pseudo header runs alongside option packing
          state     <= tx_assemble;
        end
        tx_assemble: if (opt_done) state <= tx_checksum;
        tx_checksum: if (cks_done) begin
          out_rdy <= 1'b1;
          state   <= tx_ready;
        end
        tx_ready: if (out_acc) begin
          out_rdy <= 1'b0;
          hdr_cnt <= '0;
          pld_cnt <= '0;
          state   <= tx_header;
        end
        tx_header, tx_payload: begin
          if (strm_eof) begin  // last byte already out
            strm_val <= 1'b0;
            strm_eof <= 1'b0;
            state    <= tx_idle;
          end else if (hdr_take) begin
            strm_val <= 1'b1;
            strm_sof <= hdr_cnt == 6'd0;
            strm_eof <= hdr_end && pld_len_r == 16'd0;
            hdr_cnt  <= hdr_cnt + 6'd1;
            if (hdr_end && pld_len_r != 16'd0)
              state <= tx_payload;
          end else if (pld_req) begin
            strm_val <= 1'b1;
            strm_sof <= 1'b0;
            strm_eof <= pld_end;
            pld_cnt  <= pld_cnt + 16'd1;
          end else begin
            strm_val <= 1'b0;  // no request, no byte
            strm_sof <= 1'b0;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == tx_idle && tx_rdy) begin
      src_port_r <= src_port;
      dst_port_r <= dst_port;
      seq_r      <= seq_num;
      ack_r      <= ack_num;
      flags_r    <= flags;
      wnd_r      <= wnd;
      urg_r      <= urg_ptr;
      pld_len_r  <= pld_len;
    end
    if (state == tx_checksum && cks_done)
      hdr_reg <= {hdr_words[9:2], cks, hdr_words[0], opt_words};  // cks lands in bytes 16-17
    else if (hdr_take)
      hdr_reg <= {hdr_reg[TOP_BYTE-1:0], 8'h00};
    if (hdr_take)
      strm_dat <= hdr_reg[TOP_BYTE];
    else if (pld_req)
      strm_dat <= pld_dat;
  end

  always_ff @(posedge clk) begin
    if (rst)
      seg_open <= 1'b0;
    else if (strm_eof)
      seg_open <= 1'b0;
    else if (strm_sof)
      seg_open <= 1'b1;
  end

  a_val_state: assert property (@(posedge clk) disable iff (rst)
    strm_val |-> state inside {tx_header, tx_payload});

  a_sof_once: assert property (@(posedge clk) disable iff (rst)
    strm_sof |-> !seg_open);

  a_eof_once: assert property (@(posedge clk) disable iff (rst)
    strm_eof |-> seg_open);

endmodule : tcp_tx_stream

`default_nettype wire

// ==== hdl/tcp_tx_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tcp_tx_cfg.svh"

module tcp_tx_top (
  input  logic        clk,
  input  logic        rst,
  // client descriptor
  input  logic        tx_rdy,
  output logic        tx_acc,
  input  logic [31:0] src_ip,
  input  logic [31:0] dst_ip,
  input  logic [15:0] src_port,
  input  logic [15:0] dst_port,
  input  logic [31:0] seq_num,
  input  logic [31:0] ack_num,
  input  logic [8:0]  flags,
  input  logic [15:0] wnd,
  input  logic [15:0] urg_ptr,
  input  logic [15:0] pld_len,
  input  logic [31:0] pld_cks,
  input  logic        mss_pres,
  input  logic        wnd_pres,
  input  logic        sack_perm_pres,
  input  logic        ts_pres,
  input  logic [15:0] mss,
  input  logic [7:0]  wnd_scale,
  input  logic [31:0] ts_val,
  input  logic [31:0] ts_ecr,
  // downstream
  output logic        out_rdy,
  input  logic        out_acc,
  output logic [15:0] ip_len,
  input  logic        strm_req,
  output logic        strm_val,
  output logic        strm_sof,
  output logic        strm_eof,
  output logic [7:0]  strm_dat,
  // payload source
  output logic        pld_req,
  input  logic [7:0]  pld_dat
);

  logic                                  opt_start;
  logic                                  opt_done;
  logic [`TCP_TX_MAX_OPT_WORDS-1:0][31:0] opt_words;
  logic [2:0]                            opt_count;
  logic [3:0]                            data_offset;
  logic                                  cks_start;
  logic                                  cks_done;
  logic [15:0]                           cks;
  logic [9:0][15:0]                      hdr_words;

  // option values and pseudo header fields are latched on the start pulses
  tcp_opt_assemble tcp_opt_assemble_inst (
    .clk, .rst, .opt_start,
    .mss_pres, .wnd_pres, .sack_perm_pres, .ts_pres,
    .mss, .wnd_scale, .ts_val, .ts_ecr,
    .opt_done, .opt_words, .opt_count, .data_offset
  );

  tcp_cks_calc tcp_cks_calc_inst (
    .clk, .rst, .cks_start,
    .src_ip, .dst_ip, .hdr_words, .opt_words, .data_offset,
    .pld_len, .pld_cks,
    .cks_done, .cks
  );

  tcp_tx_stream tcp_tx_stream_inst (
    .clk, .rst, .tx_rdy,
    .src_port, .dst_port, .seq_num, .ack_num, .flags, .wnd, .urg_ptr, .pld_len,
    .opt_done, .opt_words, .opt_count, .data_offset,
    .cks_done, .cks,
    .out_acc, .strm_req, .pld_dat,
    .tx_acc, .opt_start, .cks_start, .hdr_words,
    .out_rdy, .ip_len,
    .strm_val, .strm_sof, .strm_eof, .strm_dat,
    .pld_req
  );

endmodule : tcp_tx_top

`default_nettype wire

// ==== sim/tcp_tx_ref.svh ====
`ifndef TCP_TX_REF_SVH
`define TCP_TX_REF_SVH

// 32-bit LCG step, numerical recipes constants
function automatic logic [31:0] lcg_step(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// present options in wire order MSS, window scale, SACK-permitted, timestamp
function automatic void pack_options(
  input  logic        mss_p,
  input  logic        ws_p,
  input  logic        sp_p,
  input  logic        ts_p,
  input  logic [15:0] mss_v,
  input  logic [7:0]  ws_v,
  input  logic [31:0] tsv,
  input  logic [31:0] tse,
  output logic [31:0] words [$]
);
  words = {};
  if (mss_p)
    words.push_back({8'd2, 8'd4, mss_v});  // kind, length, value
  if (ws_p)
    words.push_back({8'd1, 8'd3, 8'd3, ws_v});  // one nop in front
  if (sp_p)
    words.push_back({8'd1, 8'd1, 8'd4, 8'd2});
  if (ts_p) begin
    words.push_back({8'd1, 8'd1, 8'd8, 8'd10});
    words.push_back(tsv);
    words.push_back(tse);
  end
endfunction

// header and option bytes as sent, checksum in bytes 16 and 17
function automatic void expected_header(
  input  logic [31:0] sip,
  input  logic [31:0] dip,
  input  logic [15:0] sport,
  input  logic [15:0] dport,
  input  logic [31:0] seq,
  input  logic [31:0] ack,
  input  logic [8:0]  flg,
  input  logic [15:0] win,
  input  logic [15:0] urg,
  input  logic [15:0] plen,
  input  logic [31:0] pcks,
  input  logic [31:0] opts [$],
  output logic [7:0]  hdr [$]
);
  logic [3:0]   doff;
  logic [159:0] fixed;
  logic [15:0]  tcp_len;
  logic [31:0]  sum;
  doff  = 4'(5 + opts.size());
  fixed = {sport, dport, seq, ack, doff, 3'b000, flg, win, 16'h0000, urg};
  hdr   = {};
  for (int i = 19; i >= 0; i--)
    hdr.push_back(fixed[i * 8 +: 8]);
  foreach (opts[w])
    for (int b = 3; b >= 0; b--)
      hdr.push_back(opts[w][b * 8 +: 8]);
  tcp_len = 16'(hdr.size()) + plen;
  // pseudo header: addresses, zero and protocol 6, tcp length
  sum = {16'h0, sip[31:16]} + {16'h0, sip[15:0]} + {16'h0, dip[31:16]} + {16'h0, dip[15:0]};
  sum = sum + 32'd6 + {16'h0, tcp_len};
  for (int i = 0; i < hdr.size(); i += 2)
    sum = sum + {16'h0, hdr[i], hdr[i + 1]};
  sum = sum + {16'h0, pcks[31:16]} + {16'h0, pcks[15:0]};
  while (sum[31:16] != 16'h0)
    sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};  // end-around carry
  hdr[16] = ~sum[15:8];
  hdr[17] = ~sum[7:0];
endfunction

`endif

// ==== sim/tcp_tx_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tcp_tx_cfg.svh"

module tcp_tx_tb;

  localparam int          PERIOD     = 20;
  localparam int          RST_CYCLES = 5;
  localparam logic [31:0] SEED       = 32'h2bda059a;
  localparam int          MAX_PLD    = 64;
  localparam int          RAND_SEGS  = 20;
  localparam int          SEG_COUNT  = RAND_SEGS + 4;
  // longest latency plus four cycles for every byte of the largest segment
  localparam int          SEG_CYCLES = 9 + 2 * 11 + 4 * (`TCP_TX_MAX_HDR_BYTES + MAX_PLD) + 8;
  localparam int          TIMEOUT_NS = (RST_CYCLES + 20 + SEG_COUNT * SEG_CYCLES) * PERIOD;

  logic        clk = 1'b0;
  logic        rst;
  logic        tx_rdy;
  logic        tx_acc;
  logic [31:0] src_ip;
  logic [31:0] dst_ip;
  logic [15:0] src_port;
  logic [15:0] dst_port;
  logic [31:0] seq_num;
  logic [31:0] ack_num;
  logic [8:0]  flags;
  logic [15:0] wnd;
  logic [15:0] urg_ptr;
  logic [15:0] pld_len;
  logic [31:0] pld_cks;
  logic        mss_pres;
  logic        wnd_pres;
  logic        sack_perm_pres;
  logic        ts_pres;
  logic [15:0] mss;
  logic [7:0]  wnd_scale;
  logic [31:0] ts_val;
  logic [31:0] ts_ecr;
  logic        out_rdy;
  logic        out_acc;
  logic [15:0] ip_len;
  logic        strm_req;
  logic        strm_val;
  logic        strm_sof;
  logic        strm_eof;
  logic [7:0]  strm_dat;
  logic        pld_req;
  logic [7:0]  pld_dat;

  logic [31:0] lcg_state = SEED;
  int          err_cnt   = 0;
  int          pass_cnt  = 0;
  int          fail_cnt  = 0;
  int          test_num  = 0;
  int          err_base  = 0;
  logic [7:0]  pld_mem [0:MAX_PLD-1];
  logic [5:0]  pld_idx   = '0;
  logic [7:0]  got_q [$];
  logic [7:0]  prev_q [$];
  logic        seg_done  = 1'b0;
  logic [15:0] seg_ip_len;

  `include "tcp_tx_ref.svh"

  tcp_tx_top tcp_tx_top_inst (.*);

  always #(PERIOD / 2) clk = ~clk;

  task automatic log_error(input string msg);
    $display("error %0t: %s", $time, msg);
    err_cnt++;
  endtask

  function automatic logic [31:0] rand32();
    lcg_state = lcg_step(lcg_state);
    return lcg_state;
  endfunction

  task automatic start_test();
    test_num++;
    err_base = err_cnt;
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == err_base) begin
      pass_cnt++;
      $display("test %0d %s: passed", test_num, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: failed with %0d errors", test_num, name, err_cnt - err_base);
    end
  endtask

  task automatic randomize_fields();
    src_ip    = rand32();
    dst_ip    = rand32();
    src_port  = 16'(rand32() >> 16);
    dst_port  = 16'(rand32() >> 16);
    seq_num   = rand32();
    ack_num   = rand32();
    flags     = 9'(rand32() >> 23);
    wnd       = 16'(rand32() >> 16);
    urg_ptr   = 16'(rand32() >> 16);
    mss       = 16'(rand32() >> 16);
    wnd_scale = 8'(rand32() >> 24);
    ts_val    = rand32();
    ts_ecr    = rand32();
  endtask

  task automatic fill_payload();
    for (int i = 0; i < MAX_PLD; i++)
      pld_mem[i] = 8'(rand32() >> 24);
  endtask

  // ones' complement partial sum of the payload, odd byte padded with zero
  function automatic logic [31:0] payload_sum(input int len);
    logic [31:0] s;
    s = 32'h0;
    for (int i = 0; i < len; i += 2)
      s = s + {16'h0, pld_mem[i], ((i + 1 < len) ? pld_mem[i + 1] : 8'h00)};
    return s;
  endfunction

  // one descriptor through the engine, bytes checked against the model
  task automatic send_segment(input bit throttle);
    logic [31:0] opts [$];
    logic [7:0]  exp_q [$];
    logic [31:0] rnd;
    int          wait_cyc;
    pack_options(mss_pres, wnd_pres, sack_perm_pres, ts_pres, mss, wnd_scale, ts_val, ts_ecr,
                 opts);
    expected_header(src_ip, dst_ip, src_port, dst_port, seq_num, ack_num, flags, wnd, urg_ptr,
                    pld_len, pld_cks, opts, exp_q);
    for (int i = 0; i < pld_len; i++)
      exp_q.push_back(pld_mem[i]);
    got_q    = {};
    seg_done = 1'b0;
    tx_rdy   = 1'b1;
    @(posedge clk);
    while (!tx_acc)
      @(posedge clk);
    #2 tx_rdy = 1'b0;
    wait_cyc = 0;
    do begin
      @(posedge clk);
      wait_cyc++;
    end while (!out_rdy);
    assert (wait_cyc == 9 + 2 * (5 + opts.size()))
      else log_error($sformatf("out_rdy after %0d cycles, expected %0d", wait_cyc,
                               9 + 2 * (5 + opts.size())));
    seg_ip_len = ip_len;
    assert (ip_len == 16'(exp_q.size()))
      else log_error($sformatf("ip_len %0d, expected %0d", ip_len, exp_q.size()));
    #2 out_acc = 1'b1;
    @(posedge clk);
    #2 out_acc = 1'b0;
    while (!seg_done) begin
      rnd      = rand32();
      strm_req = throttle ? rnd[20] : 1'b1;
      @(posedge clk);
      #2;
    end
    strm_req = 1'b0;
    assert (got_q.size() == exp_q.size())
      else log_error($sformatf("segment of %0d bytes, expected %0d", got_q.size(), exp_q.size()));
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
      assert (got_q[i] == exp_q[i])
        else log_error($sformatf("byte %0d is %h, expected %h", i, got_q[i], exp_q[i]));
  endtask

  // payload source, the byte under pld_idx is consumed whenever pld_req is high
  assign pld_dat = pld_mem[pld_idx];

  always @(posedge clk) begin
    if (rst || tx_acc)
      pld_idx <= '0;
    else if (pld_req)
      pld_idx <= pld_idx + 6'd1;
  end

  // collector
  always @(posedge clk) begin
    if (!rst && strm_val) begin
      assert (strm_sof == (got_q.size() == 0))
        else log_error($sformatf("sof is %b on byte %0d", strm_sof, got_q.size()));
      got_q.push_back(strm_dat);
      if (strm_eof)
        seg_done = 1'b1;
    end
  end

  a_req_before_byte: assert property (@(posedge clk) disable iff (rst)
    strm_val |-> $past(strm_req))
    else log_error("byte produced without a request");

  a_marks_on_byte: assert property (@(posedge clk) disable iff (rst)
    (strm_sof || strm_eof) |-> strm_val)
    else log_error("sof or eof without a valid byte");

  a_pld_req_follows: assert property (@(posedge clk) disable iff (rst)
    pld_req |-> strm_req)
    else log_error("pld_req high without strm_req");

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    rst            = 1'b1;
    tx_rdy         = 1'b0;
    out_acc        = 1'b0;
    strm_req       = 1'b0;
    mss_pres       = 1'b0;
    wnd_pres       = 1'b0;
    sack_perm_pres = 1'b0;
    ts_pres        = 1'b0;
    pld_len        = '0;
    pld_cks        = '0;
    randomize_fields();
    for (int i = 0; i < MAX_PLD; i++)
      pld_mem[i] = 8'(i * 37 + 11);
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst = 1'b0;

    start_test();
    repeat (10) begin
      @(posedge clk);
      assert (!tx_acc && !out_rdy && !strm_val && !pld_req)
        else log_error("output active with no descriptor offered");
    end
    #2;
    finish_test("idle after reset");

    start_test();
    randomize_fields();
    send_segment(1'b0);
    assert (got_q.size() == `TCP_TX_MIN_HDR_BYTES && got_q[12][7:4] == 4'd5 && seg_ip_len == 20)
      else log_error($sformatf("bare header: %0d bytes, offset %0d, ip_len %0d",
                               got_q.size(), got_q[12][7:4], seg_ip_len));
    finish_test("bare header");

    start_test();
    randomize_fields();
    {mss_pres, wnd_pres, sack_perm_pres, ts_pres} = 4'b1111;
    send_segment(1'b0);
    assert (got_q.size() == `TCP_TX_MAX_HDR_BYTES && got_q[12][7:4] == 4'd11)
      else log_error($sformatf("all options: %0d bytes, offset %0d",
                               got_q.size(), got_q[12][7:4]));
    assert (got_q[20] == 8'd2 && got_q[25] == 8'd3 && got_q[30] == 8'd4 && got_q[34] == 8'd8)
      else log_error("option kinds out of order");
    finish_test("all options");

    start_test();
    randomize_fields();
    {mss_pres, wnd_pres, sack_perm_pres, ts_pres} = 4'b1001;
    fill_payload();
    pld_len = 16'(1 + rand32() % (MAX_PLD - 1));
    pld_cks = payload_sum(pld_len);
    send_segment(1'b0);
    prev_q = got_q;
    finish_test("payload");

    start_test();
    send_segment(1'b1);
    assert (got_q.size() == prev_q.size())
      else log_error("throttled segment length differs");
    for (int i = 0; i < prev_q.size() && i < got_q.size(); i++)
      assert (got_q[i] == prev_q[i])
        else log_error($sformatf("throttled byte %0d is %h, unthrottled %h",
                                 i, got_q[i], prev_q[i]));
    finish_test("throttled");

    start_test();
    repeat (RAND_SEGS) begin
      rnd = rand32();
      randomize_fields();
      {mss_pres, wnd_pres, sack_perm_pres, ts_pres} = rnd[31:28];
      pld_len = 16'(rnd[27:22]);
      pld_cks = rand32();
      fill_payload();
      send_segment(rnd[21]);
    end
    finish_test("random segments");

    $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : tcp_tx_tb

`default_nettype wire

// ==== project.f ====
+incdir+hdl
+incdir+sim
hdl/tcp_tx_pkg.sv
hdl/tcp_opt_assemble.sv
hdl/tcp_cks_calc.sv
hdl/tcp_tx_stream.sv
hdl/tcp_tx_top.sv
sim/tcp_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tcp_tx_tb -f project.f

./obj_dir/Vtcp_tx_tb | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
  echo "simulation stopped before reporting a result, see sim.log"
  exit 1
fi
echo "simulation finished without errors"
